/* sources.f */
+incdir+include
src/priv_pkg.sv
src/clint_timer.sv
src/interrupt_arbiter.sv
src/csr_file.sv
src/priv_unit.sv
verif/priv_unit_assertions.sv
verif/priv_unit_tb.sv

/* Bender.yml */
package:
  name: priv_unit

export_include_dirs:
  - include

sources:
  - files:
      - src/priv_pkg.sv
      - src/clint_timer.sv
      - src/interrupt_arbiter.sv
      - src/csr_file.sv
      - src/priv_unit.sv
  - target: test
    files:
      - verif/priv_unit_assertions.sv
      - verif/priv_unit_tb.sv

/* verif/priv_trace.txt */
# op name operands in hex: CSRW/CSRR addr data, MMIOW/MMIOR offset data, IRQ level
# EVENT kind pc, EXPTRAP trap mcause mepc, EXPPRIV mode, IDLE cycles
MMIOR rst_mtime_lo 4 00000000
MMIOR rst_cmp_lo 2 ffffffff
MMIOR rst_cmp_hi 3 ffffffff
MMIOR rst_mtime_rise 4 00000003
CSRR rst_mstatus 300 00000000
CSRR rst_mie 304 00000000
CSRR rst_mip 344 00000000
CSRR rst_sepc 141 00000000
CSRR rst_scause 142 00000000
EXPPRIV rst_mode 3
EXPTRAP rst_trap 0 00000000 00000000
CSRW warl_mpp 300 000011a0
CSRR warl_mpp_rd 300 000001a0
CSRR view_sstatus 100 00000120
CSRW warl_mepc 341 12345677
CSRR warl_mepc_rd 341 12345674
CSRW warl_sepc 141 deadbeef
CSRR warl_sepc_rd 141 deadbeec
CSRW view_mie 304 ffffffff
CSRR view_sie 104 00000222
CSRW view_mip 344 ffffffff
MMIOW view_msip 0 00000001
CSRR view_mip_rd 344 00000228
CSRR view_sip 144 00000220
MMIOW view_msip_off 0 00000000
CSRW clear_mip 344 00000000
CSRW clear_mie 304 00000000
CSRW to_u_mstatus 300 00000080
EVENT to_u MRET 00000000
EXPPRIV to_u_mode 0
EVENT ecall_u ECALL 00001004
EXPTRAP ecall_u_trap 1 00000008 00001004
EXPPRIV ecall_u_mode 3
CSRR ecall_u_mpp 300 00000080
CSRW to_s_mstatus 300 00000880
EVENT to_s MRET 00000000
EXPPRIV to_s_mode 1
EVENT ecall_s ECALL 00002008
EXPTRAP ecall_s_trap 1 00000009 00002008
EVENT ret_s MRET 00000000
EVENT ill_s ILLEGAL 0000300a
EXPTRAP ill_s_trap 1 00000002 00003008
EVENT ill_ret MRET 00000000
EXPPRIV ill_ret_mode 1
EVENT to_u2 SRET 00004000
EXPPRIV to_u2_mode 0
MMIOW prio_msip 0 00000001
MMIOW prio_ssip 1 00000001
IRQ prio_mei 1
CSRW prio_mie 304 ffffffff
IDLE prio_wait 1
EXPTRAP prio_mei_trap 1 8000000b 00004000
IRQ prio_mei_off 0
EVENT prio_ret1 MRET 00005000
IDLE prio_wait1 1
EXPTRAP prio_msi_trap 1 80000003 00005000
MMIOW prio_msip_off 0 00000000
EVENT prio_ret2 MRET 00006000
IDLE prio_wait2 1
EXPTRAP prio_ssi_trap 1 80000001 00006000
IRQ gate_mei 1
IDLE gate_wait 2
EXPTRAP gate_m_trap 0 80000001 00006000
IRQ gate_mei_off 0
CSRW gate_mstatus 300 000000a8
IDLE gate_wait_s 2
EXPTRAP gate_s_trap 0 80000001 00006000
MMIOW gate_ssip_off 1 00000000
CSRW gate_mie_off 304 00000000
MMIOW tmr_cmp_lo 2 00000010
MMIOW tmr_mtime_lo 4 00000000
MMIOR tmr_mtime_rd 4 00000000
MMIOW tmr_cmp_hi 3 00000000
CSRW tmr_mtie 304 00000080
IDLE tmr_wait 30
EXPTRAP tmr_trap 1 80000007 00006000
CSRR tmr_mip 344 00000080
MMIOW tmr_cmp_high 3 ffffffff
CSRR tmr_mip_clr 344 00000000
CSRW wlrl_irq 342 8000000b
CSRR wlrl_irq_rd 342 8000000b
CSRW wlrl_exc 342 0000000b
CSRR wlrl_exc_rd 342 0000000b
CSRW wlrl_bad_exc 342 00000005
CSRR wlrl_bad_exc_rd 342 0000000b
CSRW wlrl_bad_irq 342 80000002
CSRR wlrl_bad_irq_rd 342 0000000b

/* verif/priv_unit_tb.sv */
`timescale 1ns/10ps
`include "priv_config.svh"

module priv_unit_tb
  import priv_pkg::*;
();

  logic             clock;
  logic             reset;
  logic             csr_wr_en;
  logic [11:0]      csr_addr;
  logic [`XLEN-1:0] csr_wr_data;
  logic [`XLEN-1:0] csr_rd_data;
  logic             mmio_wr_en;
  logic [2:0]       mmio_addr;
  logic [`XLEN-1:0] mmio_wr_data;
  logic [`XLEN-1:0] mmio_rd_data;
  logic             external_interrupt;
  logic [31:0]      pc;
  logic             illegal_instruction;
  logic             ecall;
  logic             mret;
  logic             sret;
  logic             trap;
  logic [31:0]      mepc;
  logic [31:0]      sepc;
  priv_mode_e       privilege_mode;

  // Parsed trace, one entry per operation line
  string       op_q[$];
  string       name_q[$];
  string       kind_q[$];
  logic [31:0] arg_a_q[$];
  logic [31:0] arg_b_q[$];
  logic [31:0] arg_c_q[$];
  int          idle_total;
  int          error_count;
  int          check_count;
  logic        trap_seen;
  longint      watchdog_limit;
  bit          limit_ready;

  priv_unit DUT (
    .clock               (clock),
    .reset               (reset),
    .csr_wr_en           (csr_wr_en),
    .csr_addr            (csr_addr),
    .csr_wr_data         (csr_wr_data),
    .csr_rd_data         (csr_rd_data),
    .mmio_wr_en          (mmio_wr_en),
    .mmio_addr           (mmio_addr),
    .mmio_wr_data        (mmio_wr_data),
    .mmio_rd_data        (mmio_rd_data),
    .external_interrupt  (external_interrupt),
    .pc                  (pc),
    .illegal_instruction (illegal_instruction),
    .ecall               (ecall),
    .mret                (mret),
    .sret                (sret),
    .trap                (trap),
    .mepc                (mepc),
    .sepc                (sepc),
    .privilege_mode      (privilege_mode)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic check_word(input string name, input csr_word_u expected, input csr_word_u actual);
    check_count++;
    if (actual.word !== expected.word) begin
      error_count++;
      $display("Error: %s expected %h actual %h", name, expected.word, actual.word);
    end
  endtask

  task automatic check_priv(input string name, input priv_mode_e expected, input priv_mode_e actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error: %s expected mode %0d actual mode %0d", name, expected, actual);
    end
  endtask

  task automatic check_trap(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error: %s expected trap %b actual trap %b", name, expected, actual);
    end
  endtask

  task automatic read_trace();
    int                 fd;
    int                 code;
    string              op;
    string              name;
    string              kind;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [31:0]        c;
    logic [8*256-1:0]   rest_of_line;
    fd = $fopen("verif/priv_trace.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("Could not open the trace file verif/priv_trace.txt");
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", op);
      if (code != 1) break;
      if (op.substr(0, 0) == "#") begin
        code = $fgets(rest_of_line, fd);
        continue;
      end
      kind = "";
      a    = '0;
      b    = '0;
      c    = '0;
      code = $fscanf(fd, "%s", name);
      case (op)
        "EVENT":                  code = $fscanf(fd, "%s %h", kind, a);
        "EXPTRAP":                code = $fscanf(fd, "%h %h %h", a, b, c);
        "IRQ", "EXPPRIV", "IDLE": code = $fscanf(fd, "%h", a);
        default:                  code = $fscanf(fd, "%h %h", a, b);
      endcase
      op_q.push_back(op);
      name_q.push_back(name);
      kind_q.push_back(kind);
      arg_a_q.push_back(a);
      arg_b_q.push_back(b);
      arg_c_q.push_back(c);
      if (op == "IDLE") idle_total += a;
    end
    $fclose(fd);
  endtask

  // Outputs are stable well before the next edge
  task automatic sample_mid_cycle();
    #40;
    if (trap === 1'b1) trap_seen = 1'b1;
  endtask

  task automatic advance_cycle();
    @(posedge clock);
    #5;
  endtask

  task automatic run_op(input int i);
    string       name;
    logic [31:0] a;
    logic [31:0] b;
    name = name_q[i];
    a    = arg_a_q[i];
    b    = arg_b_q[i];
    case (op_q[i])
      "CSRW", "MMIOW": begin
        if (op_q[i] == "CSRW") begin
          csr_wr_en   = 1'b1;
          csr_addr    = a[11:0];
          csr_wr_data = b;
        end else begin
          mmio_wr_en   = 1'b1;
          mmio_addr    = a[2:0];
          mmio_wr_data = b;
        end
        sample_mid_cycle();
        advance_cycle();
        csr_wr_en  = 1'b0;
        mmio_wr_en = 1'b0;
      end
      "CSRR": begin
        csr_addr = a[11:0];
        sample_mid_cycle();
        check_word(name, b, csr_rd_data);
        // The sepc port mirrors the stored CSR
        if (a[11:0] == `CSR_SEPC) begin
          check_word(name, b, sepc);
        end
        advance_cycle();
      end
      "MMIOR": begin
        mmio_addr = a[2:0];
        sample_mid_cycle();
        check_word(name, b, mmio_rd_data);
        advance_cycle();
      end
      "IRQ": begin
        external_interrupt = a[0];
        sample_mid_cycle();
        advance_cycle();
      end
      "EVENT": begin
        pc = a;
        case (kind_q[i])
          "ILLEGAL": illegal_instruction = 1'b1;
          "ECALL":   ecall = 1'b1;
          "MRET":    mret = 1'b1;
          "SRET":    sret = 1'b1;
          default: begin
            error_count++;
            $display("Unknown event kind %s in step %s", kind_q[i], name);
          end
        endcase
        sample_mid_cycle();
        advance_cycle();
        illegal_instruction = 1'b0;
        ecall               = 1'b0;
        mret                = 1'b0;
        sret                = 1'b0;
      end
      "EXPTRAP": begin
        check_trap(name, a[0], trap_seen);
        trap_seen = 1'b0;
        csr_addr  = `CSR_MCAUSE;
        sample_mid_cycle();
        check_word(name, b, csr_rd_data);
        check_word(name, arg_c_q[i], mepc);
        advance_cycle();
      end
      "EXPPRIV": begin
        sample_mid_cycle();
        check_priv(name, priv_mode_e'(a[1:0]), privilege_mode);
        advance_cycle();
      end
      "IDLE": begin
        repeat (a) begin
          sample_mid_cycle();
          advance_cycle();
        end
      end
      default: begin
        error_count++;
        $display("Unknown trace operation %s in step %s", op_q[i], name);
      end
    endcase
  endtask

  initial begin
    reset               = 1'b1;
    csr_wr_en           = 1'b0;
    csr_addr            = '0;
    csr_wr_data         = '0;
    mmio_wr_en          = 1'b0;
    mmio_addr           = '0;
    mmio_wr_data        = '0;
    external_interrupt  = 1'b0;
    pc                  = '0;
    illegal_instruction = 1'b0;
    ecall               = 1'b0;
    mret                = 1'b0;
    sret                = 1'b0;
    idle_total          = 0;
    error_count         = 0;
    check_count         = 0;
    trap_seen           = 1'b0;
    read_trace();
    if (op_q.size() == 0) begin
      error_count++;
      $display("The trace holds no operations");
    end
    watchdog_limit = (op_q.size() + idle_total + 20) * 100;
    limit_ready    = 1'b1;
    repeat (10) @(posedge clock);
    #5;
    reset = 1'b0;
    foreach (op_q[i]) run_op(i);
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Limit scales with the trace length
  initial begin
    wait (limit_ready);
    #(watchdog_limit);
    $display("Run timed out after %0t before the trace was finished", $time);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* verif/priv_unit_assertions.sv */
`timescale 1ns/10ps

module priv_unit_assertions
  import priv_pkg::*;
(
  input logic        clock,
  input logic        reset,
  input logic        trap,
  input priv_mode_e  priv,
  input logic [31:0] mepc
);

  // Every trap lands in M at the following edge
  trap_enters_m: assert property (
    @(posedge clock) disable iff (reset) trap |=> (priv == PRIV_M)
  ) else $error("Trap was not followed by M-mode");

  mepc_aligned: assert property (
    @(posedge clock) disable iff (reset) (mepc[1:0] == 2'b00)
  ) else $error("mepc holds a misaligned value");

  // First reset edge skipped, state is still unknown there
  no_trap_in_reset: assert property (
    @(posedge clock) reset ##1 reset |-> !trap
  ) else $error("Trap raised while reset is high");

endmodule

bind csr_file priv_unit_assertions u_priv_unit_assertions (
  .clock (clock),
  .reset (reset),
  .trap  (trap),
  .priv  (priv),
  .mepc  (mepc)
);

/* src/priv_unit.sv */
`timescale 1ns/10ps
`include "priv_config.svh"

module priv_unit
  import priv_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             csr_wr_en,
  input  logic [11:0]      csr_addr,
  input  logic [`XLEN-1:0] csr_wr_data,
  output logic [`XLEN-1:0] csr_rd_data,
  input  logic             mmio_wr_en,
  input  logic [2:0]       mmio_addr,
  input  logic [`XLEN-1:0] mmio_wr_data,
  output logic [`XLEN-1:0] mmio_rd_data,
  input  logic             external_interrupt,
  input  logic [31:0]      pc,
  input  logic             illegal_instruction,
  input  logic             ecall,
  input  logic             mret,
  input  logic             sret,
  output logic             trap,
  output logic [31:0]      mepc,
  output logic [31:0]      sepc,
  output priv_mode_e       privilege_mode
);

  logic      msoft_pending;
  logic      ssoft_pending;
  logic      timer_pending;
  csr_word_u pending;
  csr_word_u enable;
  logic      mstatus_mie;
  logic      mstatus_sie;
  logic      irq_take;
  irq_code_e irq_code;
  csr_word_u csr_wr_word;

  assign csr_wr_word.word = csr_wr_data;

  clint_timer u_clint_timer (
    .clock         (clock),
    .reset         (reset),
    .mmio_wr_en    (mmio_wr_en),
    .mmio_addr     (mmio_addr),
    .mmio_wr_data  (mmio_wr_data),
    .mmio_rd_data  (mmio_rd_data),
    .msoft_pending (msoft_pending),
    .ssoft_pending (ssoft_pending),
    .timer_pending (timer_pending)
  );

  interrupt_arbiter u_interrupt_arbiter (
    .pending     (pending),
    .enable      (enable),
    .priv        (privilege_mode),
    .mstatus_mie (mstatus_mie),
    .mstatus_sie (mstatus_sie),
    .irq_take    (irq_take),
    .irq_code    (irq_code)
  );

  csr_file u_csr_file (
    .clock               (clock),
    .reset               (reset),
    .csr_wr_en           (csr_wr_en),
    .csr_addr            (csr_addr),
    .csr_wr_data         (csr_wr_word),
    .pc                  (pc),
    .illegal_instruction (illegal_instruction),
    .ecall               (ecall),
    .mret                (mret),
    .sret                (sret),
    .msoft_pending       (msoft_pending),
    .ssoft_pending       (ssoft_pending),
    .timer_pending       (timer_pending),
    .external_interrupt  (external_interrupt),
    .irq_take            (irq_take),
    .irq_code            (irq_code),
    .csr_rd_data         (csr_rd_data),
    .pending             (pending),
    .enable              (enable),
    .priv                (privilege_mode),
    .mstatus_mie         (mstatus_mie),
    .mstatus_sie         (mstatus_sie),
    .trap                (trap),
    .mepc                (mepc),
    .sepc                (sepc)
  );

endmodule

/* src/csr_file.sv */
`timescale 1ns/10ps
`include "priv_config.svh"

module csr_file
  import priv_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             csr_wr_en,
  input  logic [11:0]      csr_addr,
  input  csr_word_u        csr_wr_data,
  input  logic [31:0]      pc,
  input  logic             illegal_instruction,
  input  logic             ecall,
  input  logic             mret,
  input  logic             sret,
  input  logic             msoft_pending,
  input  logic             ssoft_pending,
  input  logic             timer_pending,
  input  logic             external_interrupt,
  input  logic             irq_take,
  input  irq_code_e        irq_code,
  output logic [`XLEN-1:0] csr_rd_data,
  output csr_word_u        pending,
  output csr_word_u        enable,
  output priv_mode_e       priv,
  output logic             mstatus_mie,
  output logic             mstatus_sie,
  output logic             trap,
  output logic [31:0]      mepc,
  output logic [31:0]      sepc
);

  // Interrupt bit groups
  localparam logic [`XLEN-1:0] ALL_IRQ_MASK = 'h0AAA;
  localparam logic [`XLEN-1:0] S_IRQ_MASK   = 'h0222;
  localparam logic [`XLEN-1:0] MIP_WR_MASK  = 'h0220;

  logic             st_sie;
  logic             st_mie;
  logic             st_spie;
  logic             st_mpie;
  logic             st_spp;
  logic             st_mprv;
  priv_mode_e       st_mpp;
  priv_mode_e       priv_q;
  csr_word_u        mie_q;
  csr_word_u        mip_sw_q;
  logic [31:0]      mepc_q;
  logic [31:0]      sepc_q;
  logic [`XLEN-1:0] mcause_q;
  logic [`XLEN-1:0] trap_cause;
  logic             csr_we;
  csr_word_u        mstatus_v;
  csr_word_u        sstatus_v;
  csr_word_u        sip_v;
  csr_word_u        sie_v;
  logic [`XLEN-1:0] scause_v;

  // WLRL check for mcause writes
  function automatic logic mcause_legal(input logic [`XLEN-1:0] value);
    logic [`XLEN-2:0] code;
    code = value[`XLEN-2:0];
    if (value[`XLEN-1]) begin
      return code inside {IRQ_SSI, IRQ_MSI, IRQ_STI, IRQ_MTI, IRQ_SEI, IRQ_MEI};
    end
    return code inside {2, 8, 9, 11};
  endfunction

  assign trap   = irq_take | illegal_instruction | ecall;
  assign csr_we = csr_wr_en & ~trap;

  // Interrupts win over a simultaneous exception
  always_comb begin
    trap_cause = '0;
    if (irq_take) begin
      trap_cause[`XLEN-1] = 1'b1;
      trap_cause[3:0]     = irq_code;
    end else if (illegal_instruction) begin
      trap_cause[3:0] = EXC_ILLEGAL;
    end else begin
      trap_cause[3:0] = EXC_ECALL_BASE + {2'b00, priv_q};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      st_sie  <= 1'b0;
      st_mie  <= 1'b0;
      st_spie <= 1'b0;
      st_mpie <= 1'b0;
      st_spp  <= 1'b0;
      st_mprv <= 1'b0;
      st_mpp  <= PRIV_U;
    end else if (trap) begin
      // No delegation, every trap lands in M
      st_mpie <= st_mie;
      st_mie  <= 1'b0;
      st_mpp  <= priv_q;
    end else if (mret) begin
      st_mie  <= st_mpie;
      st_mpie <= 1'b1;
      st_mpp  <= PRIV_U;
      if (st_mpp != PRIV_M) st_mprv <= 1'b0;
    end else if (sret) begin
      st_sie  <= st_spie;
      st_spie <= 1'b1;
      st_spp  <= 1'b0;
      st_mprv <= 1'b0;
    end else if (csr_we && (csr_addr == `CSR_MSTATUS)) begin
      st_sie  <= csr_wr_data.status.sie;
      st_mie  <= csr_wr_data.status.mie;
      st_spie <= csr_wr_data.status.spie;
      st_mpie <= csr_wr_data.status.mpie;
      st_spp  <= csr_wr_data.status.spp;
      st_mprv <= csr_wr_data.status.mprv;
      // Mode 2 is reserved
      if (csr_wr_data.status.mpp != 2'b10) st_mpp <= priv_mode_e'(csr_wr_data.status.mpp);
    end else if (csr_we && (csr_addr == `CSR_SSTATUS)) begin
      st_sie  <= csr_wr_data.status.sie;
      st_spie <= csr_wr_data.status.spie;
      st_spp  <= csr_wr_data.status.spp;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      priv_q <= PRIV_M;
    end else if (trap) begin
      priv_q <= PRIV_M;
    end else if (mret) begin
      priv_q <= st_mpp;
    end else if (sret) begin
      priv_q <= priv_mode_e'({1'b0, st_spp});
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mie_q    <= '0;
      mip_sw_q <= '0;
    end else if (csr_we) begin
      case (csr_addr)
        `CSR_MIE: mie_q.word <= csr_wr_data.word & ALL_IRQ_MASK;
        `CSR_SIE: mie_q.word <= (mie_q.word & ~S_IRQ_MASK) | (csr_wr_data.word & S_IRQ_MASK);
        `CSR_MIP: begin
          if (priv_q == PRIV_M) mip_sw_q.word <= csr_wr_data.word & MIP_WR_MASK;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mepc_q   <= '0;
      sepc_q   <= '0;
      mcause_q <= '0;
    end else if (trap) begin
      mepc_q   <= {pc[31:2], 2'b00};
      mcause_q <= trap_cause;
    end else if (csr_we) begin
      case (csr_addr)
        `CSR_MEPC: mepc_q <= {csr_wr_data.word[31:2], 2'b00};
        `CSR_SEPC: sepc_q <= {csr_wr_data.word[31:2], 2'b00};
        `CSR_MCAUSE: begin
          if (mcause_legal(csr_wr_data.word)) mcause_q <= csr_wr_data.word;
        end
        default: ;
      endcase
    end
  end

  // Status word and its supervisor view
  always_comb begin
    mstatus_v             = '0;
    mstatus_v.status.sie  = st_sie;
    mstatus_v.status.mie  = st_mie;
    mstatus_v.status.spie = st_spie;
    mstatus_v.status.mpie = st_mpie;
    mstatus_v.status.spp  = st_spp;
    mstatus_v.status.mpp  = st_mpp;
    mstatus_v.status.mprv = st_mprv;
    sstatus_v             = mstatus_v;
    sstatus_v.status.mie  = 1'b0;
    sstatus_v.status.mpie = 1'b0;
    sstatus_v.status.mpp  = 2'b00;
    sstatus_v.status.mprv = 1'b0;
  end

  // Hardware sources merge with the software-writable bits
  always_comb begin
    pending         = mip_sw_q;
    pending.irq.ssi = ssoft_pending;
    pending.irq.msi = msoft_pending;
    pending.irq.mti = timer_pending;
    pending.irq.mei = external_interrupt;
  end

  assign sip_v.word = pending.word & S_IRQ_MASK;
  assign sie_v.word = mie_q.word & S_IRQ_MASK;

  // M-level interrupt causes are hidden from S
  assign scause_v = (mcause_q[`XLEN-1] && (mcause_q[3:0] inside {IRQ_MSI, IRQ_MTI, IRQ_MEI}))
                    ? '0 : mcause_q;

  always_comb begin
    case (csr_addr)
      `CSR_SSTATUS: csr_rd_data = sstatus_v.word;
      `CSR_SIE:     csr_rd_data = sie_v.word;
      `CSR_SEPC:    csr_rd_data = sepc_q;
      `CSR_SCAUSE:  csr_rd_data = scause_v;
      `CSR_SIP:     csr_rd_data = sip_v.word;
      `CSR_MSTATUS: csr_rd_data = mstatus_v.word;
      `CSR_MIE:     csr_rd_data = mie_q.word;
      `CSR_MEPC:    csr_rd_data = mepc_q;
      `CSR_MCAUSE:  csr_rd_data = mcause_q;
      `CSR_MIP:     csr_rd_data = pending.word;
      default:      csr_rd_data = '0;
    endcase
  end

  assign enable      = mie_q;
  assign priv        = priv_q;
  assign mstatus_mie = st_mie;
  assign mstatus_sie = st_sie;
  assign mepc        = mepc_q;
  assign sepc        = sepc_q;

endmodule

/* src/interrupt_arbiter.sv */
`timescale 1ns/10ps

module interrupt_arbiter
  import priv_pkg::*;
(
  input  csr_word_u  pending,
  input  csr_word_u  enable,
  input  priv_mode_e priv,
  input  logic       mstatus_mie,
  input  logic       mstatus_sie,
  output logic       irq_take,
  output irq_code_e  irq_code
);

  logic      m_level_ok;
  logic      s_level_ok;
  csr_word_u armed;

  // M sources preempt any lower mode, in M only with MIE set
  assign m_level_ok = (priv != PRIV_M) || mstatus_mie;

  // S sources always fire from U, from S only with SIE set, never in M
  assign s_level_ok = (priv == PRIV_U) || ((priv == PRIV_S) && mstatus_sie);

  assign armed.word = pending.word & enable.word;

  // Fixed order MEI, MSI, MTI, SEI, SSI, STI
  always_comb begin
    irq_take = 1'b1;
    irq_code = IRQ_MEI;
    if (armed.irq.mei && m_level_ok) begin
      irq_code = IRQ_MEI;
    end else if (armed.irq.msi && m_level_ok) begin
      irq_code = IRQ_MSI;
    end else if (armed.irq.mti && m_level_ok) begin
      irq_code = IRQ_MTI;
    end else if (armed.irq.sei && s_level_ok) begin
      irq_code = IRQ_SEI;
    end else if (armed.irq.ssi && s_level_ok) begin
      irq_code = IRQ_SSI;
    end else if (armed.irq.sti && s_level_ok) begin
      irq_code = IRQ_STI;
    end else begin
      // Nothing eligible, code is a don't-care
      irq_take = 1'b0;
      irq_code = IRQ_SSI;
    end
  end

endmodule

/* src/clint_timer.sv */
`timescale 1ns/10ps
`include "priv_config.svh"

module clint_timer (
  input  logic             clock,
  input  logic             reset,
  input  logic             mmio_wr_en,
  input  logic [2:0]       mmio_addr,
  input  logic [`XLEN-1:0] mmio_wr_data,
  output logic [`XLEN-1:0] mmio_rd_data,
  output logic             msoft_pending,
  output logic             ssoft_pending,
  output logic             timer_pending
);

  logic [63:0] mtime_q;
  logic [63:0] mtime_next;
  logic [63:0] mtimecmp_q;
  logic        msip_q;
  logic        ssip_q;

  // Counter advances every cycle, a written half replaces the count
  always_comb begin
    mtime_next = mtime_q + 64'd1;
    if (mmio_wr_en && (mmio_addr == `CLINT_MTIME_LO)) begin
      mtime_next[`XLEN-1:0] = mmio_wr_data;
    end
    if (mmio_wr_en && (mmio_addr == `CLINT_MTIME_HI)) begin
      mtime_next[63:`XLEN] = mmio_wr_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime_q    <= 64'd0;
      mtimecmp_q <= `MTIMECMP_RESET;
      msip_q     <= 1'b0;
      ssip_q     <= 1'b0;
    end else begin
      mtime_q <= mtime_next;
      if (mmio_wr_en) begin
        case (mmio_addr)
          `CLINT_MSIP:        msip_q <= mmio_wr_data[0];
          `CLINT_SSIP:        ssip_q <= mmio_wr_data[0];
          `CLINT_MTIMECMP_LO: mtimecmp_q[`XLEN-1:0] <= mmio_wr_data;
          `CLINT_MTIMECMP_HI: mtimecmp_q[63:`XLEN] <= mmio_wr_data;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    mmio_rd_data = '0;
    case (mmio_addr)
      `CLINT_MSIP:        mmio_rd_data[0] = msip_q;
      `CLINT_SSIP:        mmio_rd_data[0] = ssip_q;
      `CLINT_MTIMECMP_LO: mmio_rd_data = mtimecmp_q[`XLEN-1:0];
      `CLINT_MTIMECMP_HI: mmio_rd_data = mtimecmp_q[63:`XLEN];
      `CLINT_MTIME_LO:    mmio_rd_data = mtime_q[`XLEN-1:0];
      `CLINT_MTIME_HI:    mmio_rd_data = mtime_q[63:`XLEN];
      default:            mmio_rd_data = '0;
    endcase
  end

  assign msoft_pending = msip_q;
  assign ssoft_pending = ssip_q;
  // Unsigned 64-bit compare, the wide values stay inside the block
  assign timer_pending = (mtime_q >= mtimecmp_q);

endmodule

/* src/priv_pkg.sv */
`include "priv_config.svh"

package priv_pkg;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_mode_e;

  // mstatus and sstatus layout
  typedef struct packed {
    logic [`XLEN-19:0] wpri_hi;
    logic              mprv;
    logic [3:0]        wpri_16_13;
    logic [1:0]        mpp;
    logic [1:0]        wpri_10_9;
    logic              spp;
    logic              mpie;
    logic              wpri_6;
    logic              spie;
    logic              wpri_4;
    logic              mie;
    logic              wpri_2;
    logic              sie;
    logic              wpri_0;
  } status_view_t;

  // mip, mie, sip and sie layout, one bit per source
  typedef struct packed {
    logic [`XLEN-13:0] zero_hi;
    logic              mei;
    logic              zero_10;
    logic              sei;
    logic              zero_8;
    logic              mti;
    logic              zero_6;
    logic              sti;
    logic              zero_4;
    logic              msi;
    logic              zero_2;
    logic              ssi;
    logic              zero_0;
  } irq_view_t;

  typedef union packed {
    logic [`XLEN-1:0] word;
    status_view_t     status;
    irq_view_t        irq;
  } csr_word_u;

  typedef enum logic [3:0] {
    IRQ_SSI = 4'd1,
    IRQ_MSI = 4'd3,
    IRQ_STI = 4'd5,
    IRQ_MTI = 4'd7,
    IRQ_SEI = 4'd9,
    IRQ_MEI = 4'd11
  } irq_code_e;

  // Synchronous exception codes, ecall adds the current mode
  localparam logic [3:0] EXC_ILLEGAL    = 4'd2;
  localparam logic [3:0] EXC_ECALL_BASE = 4'd8;

endpackage

/* include/priv_config.svh */
`ifndef PRIV_CONFIG_SVH
`define PRIV_CONFIG_SVH

// Data width of the hart
`define XLEN 32

// Supervisor CSR addresses
`define CSR_SSTATUS 12'h100
`define CSR_SIE     12'h104
`define CSR_SEPC    12'h141
`define CSR_SCAUSE  12'h142
`define CSR_SIP     12'h144

// Machine CSR addresses
`define CSR_MSTATUS 12'h300
`define CSR_MIE     12'h304
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342
`define CSR_MIP     12'h344

// CLINT word offsets on mmio_addr
`define CLINT_MSIP        3'd0
`define CLINT_SSIP        3'd1
`define CLINT_MTIMECMP_LO 3'd2
`define CLINT_MTIMECMP_HI 3'd3
`define CLINT_MTIME_LO    3'd4
`define CLINT_MTIME_HI    3'd5

// Compare value out of reach so the timer stays quiet after reset
`define MTIMECMP_RESET 64'hFFFF_FFFF_FFFF_FFFF

`endif
